//--- axis_demux_top.f
logic/axis_demux_pkg.sv
logic/axis_demux_map_regs.sv
logic/axis_demux_route.sv
logic/axis_demux_out_slice.sv
logic/axis_demux_top.sv
sim/tb_clock_gen.sv
sim/tb_axis_demux.sv

//--- logic/axis_demux_map_regs.sv
`timescale 1ns/1ps
`default_nettype none

module axis_demux_map_regs (
    input  logic                                                 aclk,
    input  logic                                                 rst_n,
    input  logic                                                 cfg_wr,
    input  axis_demux_pkg::port_t                                cfg_index,
    input  axis_demux_pkg::tuser_t                               cfg_key,
    input  logic                                                 cfg_enable,
    output axis_demux_pkg::tuser_t [axis_demux_pkg::OUTPUTS-1:0] map_keys,
    output logic [axis_demux_pkg::OUTPUTS-1:0]                   map_enable
);
    import axis_demux_pkg::*;

    logic                       wr_hit;
    logic [$clog2(OUTPUTS)-1:0] wr_slot;

    // ======================================================================
    // write decode
    // ======================================================================

    // the extract lane has no entry of its own
    assign wr_hit = cfg_wr && (cfg_index < port_t'(OUTPUTS));

    // low bits of the index select the entry once wr_hit has checked the range
    assign wr_slot = cfg_index[$clog2(OUTPUTS)-1:0];

    // ======================================================================
    // key and enable table
    // ======================================================================

    // out of reset output i listens for key i
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < OUTPUTS; i++) begin
                map_keys[i] <= tuser_t'(i);
            end
            map_enable <= '1;
        end else if (wr_hit) begin
            map_keys[wr_slot]   <= cfg_key;
            map_enable[wr_slot] <= cfg_enable;
        end
    end

    // ======================================================================
    // checks
    // ======================================================================

    // an unknown strobe would leave the whole table in doubt
    a_cfg_wr_known: assert property (
        @(posedge aclk) disable iff (!rst_n)
        !$isunknown(cfg_wr)
    );

endmodule

`default_nettype wire

//--- logic/axis_demux_out_slice.sv
`timescale 1ns/1ps
`default_nettype none

module axis_demux_out_slice (
    input  logic                   aclk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  logic                   in_last,
    input  axis_demux_pkg::tdata_t in_data,
    input  axis_demux_pkg::tkeep_t in_keep,
    input  axis_demux_pkg::tuser_t in_user,
    input  axis_demux_pkg::tdest_t in_dest,
    input  logic                   out_ready,
    output logic                   in_ready,
    output logic                   out_valid,
    output logic                   out_last,
    output axis_demux_pkg::tdata_t out_data,
    output axis_demux_pkg::tkeep_t out_keep,
    output axis_demux_pkg::tuser_t out_user,
    output axis_demux_pkg::tdest_t out_dest
);
    import axis_demux_pkg::*;

    logic   skid_valid_q;
    logic   skid_last_q;
    tdata_t skid_data_q;
    tkeep_t skid_keep_q;
    tuser_t skid_user_q;
    tdest_t skid_dest_q;
    logic   in_xfer;
    logic   out_free;

    assign in_xfer  = in_valid && in_ready;
    // output stage takes a new beat when empty or when its beat leaves
    assign out_free = !out_valid || out_ready;

    // in_ready comes straight off a flop and drops only with both entries full
    assign in_ready = !skid_valid_q;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid    <= 1'b0;
            skid_valid_q <= 1'b0;
        end else if (out_free) begin
            // skid entry is older, so it goes out first
            out_valid    <= skid_valid_q || in_xfer;
            skid_valid_q <= 1'b0;
        end else if (in_xfer) begin
            skid_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (out_free && skid_valid_q) begin
            {out_last, out_data, out_keep, out_user, out_dest} <=
                {skid_last_q, skid_data_q, skid_keep_q, skid_user_q, skid_dest_q};
        end else if (out_free && in_xfer) begin
            {out_last, out_data, out_keep, out_user, out_dest} <=
                {in_last, in_data, in_keep, in_user, in_dest};
        end
        if (!out_free && in_xfer) begin
            {skid_last_q, skid_data_q, skid_keep_q, skid_user_q, skid_dest_q} <=
                {in_last, in_data, in_keep, in_user, in_dest};
        end
    end

    // a stalled beat holds valid and payload until the consumer takes it
    a_out_hold: assert property (
        @(posedge aclk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid
            && $stable({out_last, out_data, out_keep, out_user, out_dest})
    );

endmodule

`default_nettype wire

//--- logic/axis_demux_pkg.sv
`default_nettype none

package axis_demux_pkg;

    // ======================================================================
    // sizes
    // ======================================================================

    // mapped outputs, each with its own routing key
    localparam int OUTPUTS = 4;

    // packets that match no enabled key leave on the lane after the mapped ones
    localparam int EXTRACT_PORT = OUTPUTS;
    localparam int NUM_PORTS = OUTPUTS + 1;

    localparam int TDATA_BYTES = 4;
    localparam int TUSER_WIDTH = 4;
    localparam int TDEST_WIDTH = 2;

    // wide enough to name the extract lane too
    localparam int PORT_W = 3;

    // ======================================================================
    // stream fields
    // ======================================================================

    typedef logic [TDATA_BYTES*8-1:0] tdata_t;
    typedef logic [TDATA_BYTES-1:0] tkeep_t;

    // tuser of the first beat is the routing key
    typedef logic [TUSER_WIDTH-1:0] tuser_t;

    // tdest is not looked at, only carried
    typedef logic [TDEST_WIDTH-1:0] tdest_t;

    typedef logic [PORT_W-1:0] port_t;

    // ======================================================================
    // router FSM
    // ======================================================================

    // IDLE waits for a first beat, IN_PACKET holds the route until tlast
    typedef enum logic [0:0] {
        IDLE,
        IN_PACKET
    } route_state_t;

endpackage

`default_nettype wire

//--- logic/axis_demux_route.sv
`timescale 1ns/1ps
`default_nettype none

module axis_demux_route (
    input  logic                                                 aclk,
    input  logic                                                 rst_n,
    input  logic                                                 rx_tvalid,
    input  logic                                                 rx_tlast,
    input  axis_demux_pkg::tuser_t                               rx_tuser,
    input  axis_demux_pkg::tuser_t [axis_demux_pkg::OUTPUTS-1:0] map_keys,
    input  logic [axis_demux_pkg::OUTPUTS-1:0]                   map_enable,
    input  logic [axis_demux_pkg::NUM_PORTS-1:0]                 slice_in_ready,
    output logic                                                 rx_tready,
    output logic [axis_demux_pkg::NUM_PORTS-1:0]                 slice_in_valid
);
    import axis_demux_pkg::*;

    route_state_t state_q;
    port_t        port_q;
    port_t        match_port;
    logic         match_found;
    port_t        sel_port;
    logic         rx_xfer;

    // ======================================================================
    // key match on the first beat
    // ======================================================================

    // lowest enabled entry with an equal key wins, else the extract lane
    always_comb begin
        match_port  = port_t'(EXTRACT_PORT);
        match_found = 1'b0;
        for (int i = 0; i < OUTPUTS; i++) begin
            if (!match_found && map_enable[i] && (map_keys[i] == rx_tuser)) begin
                match_port  = port_t'(i);
                match_found = 1'b1;
            end
        end
    end

    // later beats ignore tuser and follow the latched port
    assign sel_port = (state_q == IN_PACKET) ? port_q : match_port;

    // ======================================================================
    // steering
    // ======================================================================

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            slice_in_valid[i] = rx_tvalid && (sel_port == port_t'(i));
        end
    end

    // a full slice on the chosen lane stalls rx while the others keep draining
    assign rx_tready = slice_in_ready[sel_port];
    assign rx_xfer   = rx_tvalid && rx_tready;

    // ======================================================================
    // route lock FSM
    // ======================================================================

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            port_q  <= port_t'(EXTRACT_PORT);
        end else begin
            case (state_q)
                IDLE: begin
                    if (rx_xfer) begin
                        port_q <= match_port;
                        // single-beat packets never leave IDLE
                        if (!rx_tlast) begin
                            state_q <= IN_PACKET;
                        end
                    end
                end
                IN_PACKET: begin
                    if (rx_xfer && rx_tlast) begin
                        state_q <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // ======================================================================
    // checks
    // ======================================================================

    // a valid beat is offered to exactly one existing slice
    a_valid_onehot: assert property (
        @(posedge aclk) disable iff (!rst_n)
        rx_tvalid |-> $onehot(slice_in_valid)
    );

    // later beats of a packet are offered to the lane its first beat took
    a_route_locked: assert property (
        @(posedge aclk) disable iff (!rst_n)
        (state_q == IN_PACKET) && rx_tvalid && $past(rx_tvalid)
            |-> (slice_in_valid == $past(slice_in_valid))
    );

endmodule

`default_nettype wire

//--- logic/axis_demux_top.sv
`timescale 1ns/1ps
`default_nettype none

module axis_demux_top (
    input  logic                                                   aclk,
    input  logic                                                   rst_n,
    // rx stream
    input  logic                                                   rx_tvalid,
    input  logic                                                   rx_tlast,
    input  axis_demux_pkg::tdata_t                                 rx_tdata,
    input  axis_demux_pkg::tkeep_t                                 rx_tkeep,
    input  axis_demux_pkg::tuser_t                                 rx_tuser,
    input  axis_demux_pkg::tdest_t                                 rx_tdest,
    output logic                                                   rx_tready,
    // tx streams, the last lane is the extract output
    output logic [axis_demux_pkg::NUM_PORTS-1:0]                   tx_tvalid,
    output logic [axis_demux_pkg::NUM_PORTS-1:0]                   tx_tlast,
    output axis_demux_pkg::tdata_t [axis_demux_pkg::NUM_PORTS-1:0] tx_tdata,
    output axis_demux_pkg::tkeep_t [axis_demux_pkg::NUM_PORTS-1:0] tx_tkeep,
    output axis_demux_pkg::tuser_t [axis_demux_pkg::NUM_PORTS-1:0] tx_tuser,
    output axis_demux_pkg::tdest_t [axis_demux_pkg::NUM_PORTS-1:0] tx_tdest,
    input  logic [axis_demux_pkg::NUM_PORTS-1:0]                   tx_tready,
    // key table writes
    input  logic                                                   cfg_wr,
    input  axis_demux_pkg::port_t                                  cfg_index,
    input  axis_demux_pkg::tuser_t                                 cfg_key,
    input  logic                                                   cfg_enable
);
    import axis_demux_pkg::*;

    tuser_t [OUTPUTS-1:0]   map_keys;
    logic [OUTPUTS-1:0]     map_enable;
    logic [NUM_PORTS-1:0]   slice_in_valid;
    logic [NUM_PORTS-1:0]   slice_in_ready;

    // ======================================================================
    // configuration and routing
    // ======================================================================

    axis_demux_map_regs u_map_regs (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .cfg_wr     (cfg_wr),
        .cfg_index  (cfg_index),
        .cfg_key    (cfg_key),
        .cfg_enable (cfg_enable),
        .map_keys   (map_keys),
        .map_enable (map_enable)
    );

    axis_demux_route u_route (
        .aclk           (aclk),
        .rst_n          (rst_n),
        .rx_tvalid      (rx_tvalid),
        .rx_tlast       (rx_tlast),
        .rx_tuser       (rx_tuser),
        .map_keys       (map_keys),
        .map_enable     (map_enable),
        .slice_in_ready (slice_in_ready),
        .rx_tready      (rx_tready),
        .slice_in_valid (slice_in_valid)
    );

    // ======================================================================
    // output slices
    // ======================================================================

    // every slice sees the rx payload, only the routed one gets in_valid
    for (genvar k = 0; k < NUM_PORTS; k++) begin : g_out
        axis_demux_out_slice u_slice (
            .aclk      (aclk),
            .rst_n     (rst_n),
            .in_valid  (slice_in_valid[k]),
            .in_last   (rx_tlast),
            .in_data   (rx_tdata),
            .in_keep   (rx_tkeep),
            .in_user   (rx_tuser),
            .in_dest   (rx_tdest),
            .out_ready (tx_tready[k]),
            .in_ready  (slice_in_ready[k]),
            .out_valid (tx_tvalid[k]),
            .out_last  (tx_tlast[k]),
            .out_data  (tx_tdata[k]),
            .out_keep  (tx_tkeep[k]),
            .out_user  (tx_tuser[k]),
            .out_dest  (tx_tdest[k])
        );
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it
# the simulator exits non-zero on $fatal, which fails this script
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_axis_demux \
    -f axis_demux_top.f \
    -Mdir obj_dir -o sim_axis_demux

./obj_dir/sim_axis_demux

//--- sim/tb_axis_demux.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axis_demux;
    import axis_demux_pkg::*;

    localparam int RESET_TIMEOUT = 20;
    localparam int BEAT_TIMEOUT  = 100;
    localparam int DRAIN_TIMEOUT = 300;

    typedef struct packed {
        logic   last;
        tdata_t data;
        tkeep_t keep;
        tuser_t user;
        tdest_t dest;
    } beat_t;

    // len of zero means a configuration write only
    typedef struct packed {
        logic       do_cfg;
        port_t      cfg_index;
        tuser_t     cfg_key;
        logic       cfg_enable;
        tuser_t     key;
        logic [3:0] len;
        logic       change_user;
        logic       rand_ready;
        port_t      exp_port;
    } row_t;

    logic                          aclk;
    logic                          rst_n;
    logic                          rx_tvalid;
    logic                          rx_tlast;
    tdata_t                        rx_tdata;
    tkeep_t                        rx_tkeep;
    tuser_t                        rx_tuser;
    tdest_t                        rx_tdest;
    logic                          rx_tready;
    logic [NUM_PORTS-1:0]          tx_tvalid;
    logic [NUM_PORTS-1:0]          tx_tlast;
    tdata_t [NUM_PORTS-1:0]        tx_tdata;
    tkeep_t [NUM_PORTS-1:0]        tx_tkeep;
    tuser_t [NUM_PORTS-1:0]        tx_tuser;
    tdest_t [NUM_PORTS-1:0]        tx_tdest;
    logic [NUM_PORTS-1:0]          tx_tready;
    logic                          cfg_wr;
    port_t                         cfg_index;
    tuser_t                        cfg_key;
    logic                          cfg_enable;

    logic [31:0] lfsr_state;
    logic        rand_ready_mode;
    tuser_t      model_keys [OUTPUTS];
    logic        model_enable [OUTPUTS];
    beat_t       exp_q [NUM_PORTS][$];
    row_t        rows [$];

    tb_clock_gen u_clock_gen (
        .aclk  (aclk),
        .rst_n (rst_n)
    );

    axis_demux_top u_dut (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .rx_tvalid  (rx_tvalid),
        .rx_tlast   (rx_tlast),
        .rx_tdata   (rx_tdata),
        .rx_tkeep   (rx_tkeep),
        .rx_tuser   (rx_tuser),
        .rx_tdest   (rx_tdest),
        .rx_tready  (rx_tready),
        .tx_tvalid  (tx_tvalid),
        .tx_tlast   (tx_tlast),
        .tx_tdata   (tx_tdata),
        .tx_tkeep   (tx_tkeep),
        .tx_tuser   (tx_tuser),
        .tx_tdest   (tx_tdest),
        .tx_tready  (tx_tready),
        .cfg_wr     (cfg_wr),
        .cfg_index  (cfg_index),
        .cfg_key    (cfg_key),
        .cfg_enable (cfg_enable)
    );

    // ======================================================================
    // helpers
    // ======================================================================

    task automatic fail_run(string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(string name, logic [63:0] actual, logic [63:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s is %0h, expected %0h",
                $time, name, actual, expected));
        end
    endtask

    // galois LFSR with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_step();
        logic out_bit;
        out_bit = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out_bit;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr_step()};
        end
        return value;
    endfunction

    // scan from the top so the lowest enabled match is the one kept
    function automatic port_t model_port(tuser_t key);
        port_t p;
        p = port_t'(EXTRACT_PORT);
        for (int i = OUTPUTS - 1; i >= 0; i--) begin
            if (model_enable[i] && (model_keys[i] == key)) begin
                p = port_t'(i);
            end
        end
        return p;
    endfunction

    function automatic int pending_beats();
        int total;
        total = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            total += exp_q[p].size();
        end
        return total;
    endfunction

    // inputs only change right after the falling edge
    task automatic next_negedge();
        @(negedge aclk);
        for (int p = 0; p < NUM_PORTS; p++) begin
            tx_tready[p] = rand_ready_mode ? lfsr_step() : 1'b1;
        end
    endtask

    // ======================================================================
    // stimulus table
    // ======================================================================

    function automatic void add_cfg(int index, int key, int enable);
        row_t r;
        r = '0;
        r.do_cfg     = 1'b1;
        r.cfg_index  = port_t'(index);
        r.cfg_key    = tuser_t'(key);
        r.cfg_enable = (enable != 0);
        rows.push_back(r);
    endfunction

    function automatic void add_packet(int key, int len, int change_user, int rand_ready,
                                       int exp_port);
        row_t r;
        r = '0;
        r.key         = tuser_t'(key);
        r.len         = 4'(len);
        r.change_user = (change_user != 0);
        r.rand_ready  = (rand_ready != 0);
        r.exp_port    = port_t'(exp_port);
        rows.push_back(r);
    endfunction

    task automatic load_table();
        // identity map
        add_packet(0, 1, 0, 0, 0);
        add_packet(1, 2, 0, 0, 1);
        add_packet(2, 3, 0, 0, 2);
        add_packet(3, 4, 0, 0, 3);
        // keys with no entry go to extract
        add_packet(4, 2, 0, 0, 4);
        add_packet(7, 1, 0, 0, 4);
        add_packet(15, 3, 0, 0, 4);
        add_packet(10, 2, 0, 0, 4);
        // tuser changes after the first beat
        add_packet(1, 5, 1, 0, 1);
        add_packet(3, 4, 1, 0, 3);
        add_packet(12, 3, 1, 0, 4);
        // remap entry 2, disable entry 0
        add_cfg(2, 9, 1);
        add_cfg(0, 0, 0);
        add_packet(9, 3, 0, 0, 2);
        add_packet(0, 2, 0, 0, 4);
        add_packet(2, 2, 0, 0, 4);
        // same key on entries 1 and 3
        add_cfg(3, 5, 1);
        add_cfg(1, 5, 1);
        add_packet(5, 3, 0, 0, 1);
        add_packet(3, 1, 0, 0, 4);
        // write to the extract index has no effect
        add_cfg(4, 7, 1);
        add_packet(7, 2, 0, 0, 4);
        // random back-pressure on every lane
        add_packet(1, 6, 0, 1, 4);
        add_packet(9, 4, 0, 1, 2);
        add_packet(0, 3, 0, 1, 4);
        add_packet(5, 5, 0, 1, 1);
        add_packet(2, 2, 0, 1, 4);
        add_cfg(0, 2, 1);
        add_packet(2, 4, 0, 1, 0);
        add_packet(9, 3, 1, 1, 2);
        add_packet(14, 4, 0, 1, 4);
        add_packet(5, 7, 1, 1, 1);
        add_packet(9, 1, 0, 1, 2);
    endtask

    // ======================================================================
    // driver
    // ======================================================================

    task automatic send_beat(port_t port, beat_t beat);
        int   waited;
        logic accepted;
        waited    = 0;
        accepted  = 1'b0;
        rx_tvalid = 1'b1;
        rx_tlast  = beat.last;
        rx_tdata  = beat.data;
        rx_tkeep  = beat.keep;
        rx_tuser  = beat.user;
        rx_tdest  = beat.dest;
        while (!accepted) begin
            @(posedge aclk);
            if (rx_tready) begin
                exp_q[port].push_back(beat);
                accepted = 1'b1;
            end
            next_negedge();
            waited++;
            if (!accepted && (waited > BEAT_TIMEOUT)) begin
                fail_run("timeout: rx_tready stayed low while a beat was offered");
            end
        end
        rx_tvalid = 1'b0;
    endtask

    task automatic apply_row(row_t r);
        beat_t beat;
        port_t port;
        if (r.do_cfg) begin
            cfg_wr     = 1'b1;
            cfg_index  = r.cfg_index;
            cfg_key    = r.cfg_key;
            cfg_enable = r.cfg_enable;
            next_negedge();
            cfg_wr = 1'b0;
            if (int'(r.cfg_index) < OUTPUTS) begin
                model_keys[int'(r.cfg_index)]   = r.cfg_key;
                model_enable[int'(r.cfg_index)] = r.cfg_enable;
            end
        end
        if (r.len != 4'd0) begin
            rand_ready_mode = r.rand_ready;
            port = model_port(r.key);
            check_value("expected port", 64'(port), 64'(r.exp_port));
            for (int b = 0; b < int'(r.len); b++) begin
                beat.data = tdata_t'(rand_bits(TDATA_BYTES * 8));
                beat.keep = tkeep_t'(rand_bits(TDATA_BYTES));
                beat.dest = tdest_t'(rand_bits(TDEST_WIDTH));
                beat.user = (b > 0 && r.change_user) ? tuser_t'(rand_bits(TUSER_WIDTH)) : r.key;
                beat.last = (b == int'(r.len) - 1);
                send_beat(port, beat);
            end
        end
    endtask

    // ======================================================================
    // monitor
    // ======================================================================

    always @(posedge aclk) begin
        beat_t want;
        if (rst_n) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (tx_tvalid[p] && tx_tready[p]) begin
                    if (exp_q[p].size() == 0) begin
                        fail_run($sformatf("beat on output %0d that was never sent there", p));
                    end else begin
                        want = exp_q[p].pop_front();
                        check_value($sformatf("tx_tlast[%0d]", p), 64'(tx_tlast[p]),
                            64'(want.last));
                        check_value($sformatf("tx_tdata[%0d]", p), 64'(tx_tdata[p]),
                            64'(want.data));
                        check_value($sformatf("tx_tkeep[%0d]", p), 64'(tx_tkeep[p]),
                            64'(want.keep));
                        check_value($sformatf("tx_tuser[%0d]", p), 64'(tx_tuser[p]),
                            64'(want.user));
                        check_value($sformatf("tx_tdest[%0d]", p), 64'(tx_tdest[p]),
                            64'(want.dest));
                    end
                end
            end
        end
    end

    // ======================================================================
    // main sequence
    // ======================================================================

    initial begin
        int waited;
        int pending;
        lfsr_state      = 32'h6852;
        rand_ready_mode = 1'b0;
        rx_tvalid       = 1'b0;
        rx_tlast        = 1'b0;
        rx_tdata        = '0;
        rx_tkeep        = '0;
        rx_tuser        = '0;
        rx_tdest        = '0;
        tx_tready       = '1;
        cfg_wr          = 1'b0;
        cfg_index       = '0;
        cfg_key         = '0;
        cfg_enable      = 1'b0;
        for (int i = 0; i < OUTPUTS; i++) begin
            model_keys[i]   = tuser_t'(i);
            model_enable[i] = 1'b1;
        end
        load_table();

        waited = 0;
        while (rst_n !== 1'b1) begin
            @(posedge aclk);
            waited++;
            if (waited > RESET_TIMEOUT) begin
                fail_run("timeout: reset was never released");
            end
        end
        next_negedge();
        check_value("tx_tvalid", 64'(tx_tvalid), 64'd0);
        check_value("rx_tready", 64'(rx_tready), 64'd1);

        for (int i = 0; i < rows.size(); i++) begin
            apply_row(rows[i]);
        end

        // drain with every tx_tready held high
        rand_ready_mode = 1'b0;
        waited  = 0;
        pending = pending_beats();
        while ((pending != 0) && (waited <= DRAIN_TIMEOUT)) begin
            next_negedge();
            waited++;
            pending = pending_beats();
        end

        if (pending != 0) begin
            fail_run($sformatf("timeout: drain ended with %0d beats never seen", pending));
        end else begin
            // idle cycles so a duplicated beat would still show up
            for (int i = 0; i < 4; i++) begin
                next_negedge();
            end
            check_value("tx_tvalid", 64'(tx_tvalid), 64'd0);
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic aclk,
    output logic rst_n
);

    // 40 ns period
    initial begin
        aclk = 1'b0;
        forever begin
            #20 aclk = ~aclk;
        end
    end

    // reset held over two rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge aclk);
        @(negedge aclk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire
